/* bench/cpu_trace.txt */
# P <word address> <instruction word>   program image, from address 0 upward
# S <store address> <store data>        expected stores in program order, E ends the trace
P 0000 41000007   # ADDI r1, r0, 7
P 0001 4200fffd   # ADDI r2, r0, -3
P 0002 13210000   # SUB  r3, r2, r1     start of dependent chain
P 0003 24310000   # AND  r4, r3, r1
P 0004 35420000   # OR   r5, r4, r2
P 0005 06510000   # ADD  r6, r5, r1
P 0006 47007fff   # ADDI r7, r0, 0x7fff
P 0007 58770000   # MUL  r8, r7, r7
P 0008 59720000   # MUL  r9, r7, r2     back to back with the one above
P 0009 0a110000   # ADD  r10, r1, r1    ALU op right behind two MULs
P 000a 5b880000   # MUL  r11, r8, r8    product wraps past 32 bits
P 000b 40100055   # ADDI r0, r1, 0x55   write to r0 is dropped
P 000c 60030100   # SW   r3 -> [r0 + 0x100]
P 000d 60040101   # SW   r4 -> [r0 + 0x101]
P 000e 60050102   # SW   r5 -> [r0 + 0x102]
P 000f 60060103   # SW   r6 -> [r0 + 0x103]
P 0010 60080104   # SW   r8 -> [r0 + 0x104]
P 0011 60090105   # SW   r9 -> [r0 + 0x105]
P 0012 600a0106   # SW   r10 -> [r0 + 0x106]
P 0013 600b0107   # SW   r11 -> [r0 + 0x107]
P 0014 60000108   # SW   r0 -> [r0 + 0x108]
P 0015 60120102   # SW   r2 -> [r1 + 0x102]
P 0016 70000000   # HALT
S 0100 fffffff6
S 0101 00000006
S 0102 ffffffff
S 0103 00000006
S 0104 3fff0001
S 0105 fffe8003
S 0106 0000000e
S 0107 7ffe0001
S 0108 00000000
S 0109 fffffffd
E

/* tb.f */
src/cpu_pkg.sv
src/fetch.sv
src/decode.sv
src/regfile.sv
src/exec.sv
src/mul_pipe.sv
src/mem_arbiter.sv
src/cpu.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   -f tb.f --top-module cpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   exit 1
fi
exit 0

/* bench/cpu_tb.sv */
module cpu_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          MUL_STAGES = 3;
   localparam int          PROG_DEPTH = 256;
   localparam logic [31:0] SEED       = 32'h72de_6656;

   typedef struct packed {
      cpu_pkg::addr_t addr;
      cpu_pkg::word_t data;
   } store_t;

   logic           clk;
   logic           rst;
   logic           mem_enable;
   logic           mem_rw;
   cpu_pkg::addr_t mem_addr;
   cpu_pkg::word_t mem_wdata;
   cpu_pkg::word_t mem_rdata;
   logic           mem_ack;
   logic           halted;

   cpu_pkg::word_t prog [PROG_DEPTH];   // Program image from the trace
   int             prog_len;
   store_t         exp_stores [$];      // Expected stores, oldest first
   bit             trace_loaded;
   logic [31:0]    rng;
   int             wait_cnt;            // Cycles left before the ack
   bit             in_access;
   int             fetch_pc;            // Address the next fetch must use

   cpu #(.MUL_STAGES(MUL_STAGES)) u_dut (
      .clk(clk), .rst(rst),
      .mem_enable(mem_enable), .mem_rw(mem_rw), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
      .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic value_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
      $display("error: time %0d ns, signal %s, expected %h, actual %h",
               $time, sig, expected, actual);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic fail_with(input string what);
      $display("%s (time %0d ns)", what, $time);
      $display("Test failed");
      $fatal(1);
   endtask

   // Lines start with P, S or E; anything else is a comment
   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      string       rest;
      byte         kind;
      logic [31:0] f1;
      logic [31:0] f2;
      bit          seen_end;
      fd = $fopen("bench/cpu_trace.txt", "r");
      assert (fd != 0) else fail_with("cannot open bench/cpu_trace.txt");
      seen_end = 1'b0;
      while (!seen_end && !$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() < 1) begin
            continue;
         end
         kind = line.getc(0);
         if (kind == "E") begin
            seen_end = 1'b1;
         end else if (kind == "P" || kind == "S") begin
            rest = line.substr(1, line.len() - 1);
            n = $sscanf(rest, "%h %h", f1, f2);
            assert (n == 2) else fail_with({"malformed trace line: ", line});
            if (kind == "P") begin
               assert (f1 == 32'(prog_len) && prog_len < PROG_DEPTH)
                  else fail_with("program addresses in the trace are not consecutive");
               prog[prog_len] = f2;
               prog_len       = prog_len + 1;
            end else begin
               exp_stores.push_back('{addr: f1[15:0], data: f2});
            end
         end
      end
      $fclose(fd);
      assert (seen_end) else fail_with("trace file has no E line");
   endtask

   // Reads must walk the program in order, writes must match the next S entry
   task automatic answer_access();
      store_t expected;
      if (mem_rw) begin
         assert (exp_stores.size() > 0)
            else fail_with($sformatf("unexpected store to address %h", mem_addr));
         expected = exp_stores.pop_front();
         assert (mem_addr == expected.addr)
            else value_mismatch("mem_addr", 32'(expected.addr), 32'(mem_addr));
         assert (mem_wdata == expected.data)
            else value_mismatch("mem_wdata", expected.data, mem_wdata);
      end else begin
         assert (32'(mem_addr) == 32'(fetch_pc))
            else value_mismatch("mem_addr", 32'(fetch_pc), 32'(mem_addr));
         assert (fetch_pc < prog_len)
            else fail_with($sformatf("fetch from %h past the end of the program", mem_addr));
         mem_rdata = prog[fetch_pc];
         fetch_pc  = fetch_pc + 1;
      end
   endtask

   // One call per falling edge
   task automatic serve_memory();
      if (mem_ack) begin
         mem_ack   = 1'b0;   // One cycle wide
         in_access = 1'b0;
      end else if (mem_enable) begin
         if (!in_access) begin
            rng       = next_random(rng);
            wait_cnt  = int'((rng >> 16) % 6);   // 0 to 5 cycles
            in_access = 1'b1;
         end
         if (wait_cnt == 0) begin
            answer_access();
            mem_ack = 1'b1;
         end else begin
            wait_cnt = wait_cnt - 1;
         end
      end
   endtask

   initial begin
      rst       = 1'b1;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      rng       = SEED;
      wait_cnt  = 0;
      in_access = 1'b0;
      fetch_pc  = 0;
      prog_len  = 0;
      load_trace();
      trace_loaded = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      while (!halted) begin
         @(negedge clk);
         serve_memory();
      end
      // Last store must already be done when halted shows up
      assert (exp_stores.size() == 0)
         else fail_with($sformatf("halted with %0d expected stores missing",
                                  exp_stores.size()));
      assert (fetch_pc == prog_len)
         else value_mismatch("fetch count", 32'(prog_len), 32'(fetch_pc));
      repeat (10) begin
         @(negedge clk);
         assert (!mem_enable) else fail_with("memory request after halted");
         assert (halted) else fail_with("halted dropped after it was raised");
      end
      $display("Test passed");
      $finish;
   end

   // Watchdog, budget grows with program length
   initial begin
      int limit;
      wait (trace_loaded);
      limit = 3 + 10 + prog_len * (5 + MUL_STAGES + 4);
      repeat (limit) @(posedge clk);
      fail_with($sformatf("timeout, halted not reached within %0d cycles", limit));
   end

endmodule

/* bench/cpu_asserts.sv */
module cpu_asserts (
   input logic           clk,
   input logic           rst,
   input logic           mem_enable,
   input logic           mem_rw,
   input cpu_pkg::addr_t mem_addr,
   input cpu_pkg::word_t mem_wdata,
   input logic           mem_ack,
   input logic           halted
);
   timeunit 1ns;
   timeprecision 100ps;

   enable_low_after_reset: assert property (@(posedge clk) rst |=> !mem_enable)
      else $error("mem_enable high right after reset");

   // Request held steady until acked
   request_stable: assert property (@(posedge clk) disable iff (rst)
      mem_enable && !mem_ack |=> mem_enable && $stable(mem_rw)
                                 && $stable(mem_addr) && $stable(mem_wdata))
      else $error("memory request changed before ack");

   enable_drops_after_ack: assert property (@(posedge clk) disable iff (rst)
      mem_enable && mem_ack |=> !mem_enable)
      else $error("mem_enable still high in the cycle after ack");

   quiet_when_halted: assert property (@(posedge clk) disable iff (rst)
      halted |-> !mem_enable)
      else $error("memory request while halted");

endmodule

bind cpu cpu_asserts u_asserts (
   .clk(clk), .rst(rst), .mem_enable(mem_enable), .mem_rw(mem_rw),
   .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ack(mem_ack), .halted(halted)
);

/* src/cpu.sv */
module cpu #(
   parameter int MUL_STAGES = 3
) (
   input  logic           clk,
   input  logic           rst,
   output logic           mem_enable,
   output logic           mem_rw,
   output cpu_pkg::addr_t mem_addr,
   output cpu_pkg::word_t mem_wdata,
   input  cpu_pkg::word_t mem_rdata,
   input  logic           mem_ack,
   output logic           halted
);

   logic              instr_valid;
   logic              instr_take;
   cpu_pkg::instr_t   instr;
   logic              if_valid;
   cpu_pkg::mem_req_t if_req;
   logic              if_done;
   cpu_pkg::word_t    if_rdata;
   cpu_pkg::reg_idx_t rs1_idx;
   cpu_pkg::reg_idx_t rs2_idx;
   cpu_pkg::word_t    rs1_data;
   cpu_pkg::word_t    rs2_data;
   cpu_pkg::issue_t   alu_issue;
   cpu_pkg::issue_t   mul_issue;
   cpu_pkg::wb_t      alu_wb;
   cpu_pkg::wb_t      mul_wb;
   cpu_pkg::wb_t      reg_wb;
   logic              st_valid;
   cpu_pkg::mem_req_t st_req;
   logic              st_done;

   fetch u_fetch (
      .clk(clk), .rst(rst), .halt(halted),
      .instr_take(instr_take), .instr_valid(instr_valid), .instr(instr),
      .req_valid(if_valid), .req(if_req), .req_done(if_done), .rdata(if_rdata)
   );

   decode #(.MUL_STAGES(MUL_STAGES)) u_decode (
      .clk(clk), .rst(rst),
      .instr_valid(instr_valid), .instr(instr), .instr_take(instr_take),
      .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_data(rs1_data), .rs2_data(rs2_data),
      .alu_issue(alu_issue), .mul_issue(mul_issue), .alu_wb(alu_wb), .mul_wb(mul_wb),
      .st_valid(st_valid), .st_req(st_req), .st_done(st_done), .halt(halted)
   );

   regfile u_regfile (
      .clk(clk), .rst(rst), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
      .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(reg_wb)
   );

   exec u_exec (.clk(clk), .rst(rst), .issue(alu_issue), .wb(alu_wb));

   mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul_pipe (
      .clk(clk), .rst(rst), .issue(mul_issue), .wb(mul_wb)
   );

   mem_arbiter u_mem_arbiter (
      .clk(clk), .rst(rst),
      .if_valid(if_valid), .if_req(if_req), .if_done(if_done),
      .st_valid(st_valid), .st_req(st_req), .st_done(st_done), .rdata(if_rdata),
      .mem_enable(mem_enable), .mem_rw(mem_rw), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack)
   );

   // Decode keeps the two writebacks apart, so a plain select is enough
   assign reg_wb.valid = alu_wb.valid | mul_wb.valid;
   assign reg_wb.rd    = alu_wb.valid ? alu_wb.rd : mul_wb.rd;
   assign reg_wb.data  = alu_wb.valid ? alu_wb.data : mul_wb.data;

endmodule

/* src/mem_arbiter.sv */
module mem_arbiter (
   input  logic              clk,
   input  logic              rst,
   input  logic              if_valid,
   input  cpu_pkg::mem_req_t if_req,
   output logic              if_done,
   input  logic              st_valid,
   input  cpu_pkg::mem_req_t st_req,
   output logic              st_done,
   output cpu_pkg::word_t    rdata,
   output logic              mem_enable,
   output logic              mem_rw,
   output cpu_pkg::addr_t    mem_addr,
   output cpu_pkg::word_t    mem_wdata,
   input  cpu_pkg::word_t    mem_rdata,
   input  logic              mem_ack
);

   typedef enum logic [1:0] {A_IDLE, A_BUSY_FETCH, A_BUSY_STORE} arb_state_t;

   arb_state_t        state;
   cpu_pkg::mem_req_t cur;       // Request currently on the port

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= A_IDLE;
      end else begin
         case (state)
            A_IDLE: begin
               if (st_valid) begin
                  state <= A_BUSY_STORE;   // Stores win
               end else if (if_valid) begin
                  state <= A_BUSY_FETCH;
               end
            end
            default: begin
               if (mem_ack) begin
                  state <= A_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == A_IDLE) begin
         cur <= st_valid ? st_req : if_req;
      end
   end

   assign mem_enable = (state != A_IDLE);
   assign mem_rw     = cur.rw;
   assign mem_addr   = cur.addr;
   assign mem_wdata  = cur.wdata;

   assign if_done = (state == A_BUSY_FETCH) && mem_ack;
   assign st_done = (state == A_BUSY_STORE) && mem_ack;
   assign rdata   = mem_rdata;   // Valid with the ack

endmodule

/* src/mul_pipe.sv */
module mul_pipe #(
   parameter int MUL_STAGES = 3
) (
   input  logic            clk,
   input  logic            rst,
   input  cpu_pkg::issue_t issue,
   output cpu_pkg::wb_t    wb
);

   cpu_pkg::wb_t stage [MUL_STAGES];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < MUL_STAGES; i++) begin
            stage[i].valid <= 1'b0;
         end
      end else begin
         stage[0].valid <= issue.valid && (issue.op == cpu_pkg::OP_MUL);
         for (int i = 1; i < MUL_STAGES; i++) begin
            stage[i].valid <= stage[i-1].valid;
         end
      end
      stage[0].rd   <= issue.rd;
      stage[0].data <= issue.a * issue.b;   // Low word of the product
      for (int i = 1; i < MUL_STAGES; i++) begin
         stage[i].rd   <= stage[i-1].rd;
         stage[i].data <= stage[i-1].data;
      end
   end

   assign wb = stage[MUL_STAGES-1];

endmodule

/* src/exec.sv */
module exec (
   input  logic            clk,
   input  logic            rst,
   input  cpu_pkg::issue_t issue,
   output cpu_pkg::wb_t    wb
);

   cpu_pkg::word_t result;

   always_comb begin
      case (issue.op)
         cpu_pkg::OP_SUB: result = issue.a - issue.b;
         cpu_pkg::OP_AND: result = issue.a & issue.b;
         cpu_pkg::OP_OR:  result = issue.a | issue.b;
         default:         result = issue.a + issue.b;   // ADD and ADDI
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.valid <= 1'b0;
      end else begin
         wb.valid <= issue.valid;
      end
      wb.rd   <= issue.rd;
      wb.data <= result;
   end

endmodule

/* src/regfile.sv */
module regfile (
   input  logic              clk,
   input  logic              rst,
   input  cpu_pkg::reg_idx_t rs1_idx,
   input  cpu_pkg::reg_idx_t rs2_idx,
   output cpu_pkg::word_t    rs1_data,
   output cpu_pkg::word_t    rs2_data,
   input  cpu_pkg::wb_t      wb
);

   cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid && wb.rd != '0) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // r0 hardwired, then write-through
   assign rs1_data = (rs1_idx == '0) ? '0 :
                     (wb.valid && wb.rd == rs1_idx) ? wb.data : regs[rs1_idx];
   assign rs2_data = (rs2_idx == '0) ? '0 :
                     (wb.valid && wb.rd == rs2_idx) ? wb.data : regs[rs2_idx];

endmodule

/* src/decode.sv */
module decode #(
   parameter int MUL_STAGES = 3
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              instr_valid,
   input  cpu_pkg::instr_t   instr,
   output logic              instr_take,
   output cpu_pkg::reg_idx_t rs1_idx,
   output cpu_pkg::reg_idx_t rs2_idx,
   input  cpu_pkg::word_t    rs1_data,
   input  cpu_pkg::word_t    rs2_data,
   output cpu_pkg::issue_t   alu_issue,
   output cpu_pkg::issue_t   mul_issue,
   input  cpu_pkg::wb_t      alu_wb,
   input  cpu_pkg::wb_t      mul_wb,
   output logic              st_valid,
   output cpu_pkg::mem_req_t st_req,
   input  logic              st_done,
   output logic              halt
);

   localparam int SLOT_W = MUL_STAGES - 1;

   cpu_pkg::opcode_t             op;
   cpu_pkg::word_t               imm_ext;
   cpu_pkg::word_t               operand_b;
   cpu_pkg::word_t               st_addr;
   logic [cpu_pkg::NUM_REGS-1:0] busy;        // Scoreboard, one bit per register
   logic [cpu_pkg::NUM_REGS-1:0] wb_clear;
   logic [cpu_pkg::NUM_REGS-1:0] pending;
   logic [cpu_pkg::NUM_REGS-1:0] issue_set;
   logic [SLOT_W-1:0]            mul_slot;    // Bit k set when a MUL went out k+1 cycles ago
   logic is_alu, is_mul, is_store, is_halt;
   logic use_rs2, writes_rd;
   logic hazard;
   logic halt_seen;

   assign op      = instr.opcode;
   assign imm_ext = {{16{instr.imm[15]}}, instr.imm};
   assign rs1_idx = instr.rs1;
   assign rs2_idx = instr.rs2;

   assign is_mul    = (op == cpu_pkg::OP_MUL);
   assign is_store  = (op == cpu_pkg::OP_SW);
   assign is_halt   = (op == cpu_pkg::OP_HALT);
   assign is_alu    = op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                                 cpu_pkg::OP_OR, cpu_pkg::OP_ADDI};
   assign use_rs2   = (is_alu && op != cpu_pkg::OP_ADDI) || is_mul || is_store;
   assign writes_rd = is_alu || is_mul;

   // A writeback seen this cycle is already readable through the regfile bypass
   always_comb begin
      wb_clear = '0;
      if (alu_wb.valid) begin
         wb_clear[alu_wb.rd] = 1'b1;
      end
      if (mul_wb.valid) begin
         wb_clear[mul_wb.rd] = 1'b1;
      end
   end

   assign pending = busy & ~wb_clear;

   assign hazard = (!is_halt && pending[instr.rs1])
                 || (use_rs2 && pending[instr.rs2])
                 || (writes_rd && pending[instr.rd])
                 || (is_alu && mul_slot[SLOT_W-1])       // Same writeback cycle as a MUL
                 || (is_store && st_valid && !st_done);

   assign instr_take = instr_valid && !halt_seen && !hazard;

   always_comb begin
      issue_set = '0;
      if (instr_take && writes_rd && instr.rd != '0) begin
         issue_set[instr.rd] = 1'b1;
      end
   end

   assign operand_b = (op == cpu_pkg::OP_ADDI) ? imm_ext : rs2_data;
   assign st_addr   = rs1_data + imm_ext;

   assign alu_issue = '{valid: instr_take && is_alu, op: op, rd: instr.rd,
                        a: rs1_data, b: operand_b};
   assign mul_issue = '{valid: instr_take && is_mul, op: op, rd: instr.rd,
                        a: rs1_data, b: operand_b};

   always_ff @(posedge clk) begin
      if (rst) begin
         busy      <= '0;
         mul_slot  <= '0;
         st_valid  <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         busy     <= pending | issue_set;
         mul_slot <= (mul_slot << 1) | SLOT_W'(mul_issue.valid);
         if (instr_take && is_store) begin
            st_valid <= 1'b1;
         end else if (st_done) begin
            st_valid <= 1'b0;
         end
         if (instr_take && is_halt) begin
            halt_seen <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (instr_take && is_store) begin
         st_req <= '{rw: 1'b1, addr: st_addr[15:0], wdata: rs2_data};
      end
   end

   // Drained once nothing is pending and the last store has been acked
   assign halt = halt_seen && (busy == '0) && !st_valid;

endmodule

/* src/fetch.sv */
module fetch (
   input  logic              clk,
   input  logic              rst,
   input  logic              halt,
   input  logic              instr_take,
   output logic              instr_valid,
   output cpu_pkg::instr_t   instr,
   output logic              req_valid,
   output cpu_pkg::mem_req_t req,
   input  logic              req_done,
   input  cpu_pkg::word_t    rdata
);

   typedef enum logic [1:0] {F_REQUEST, F_WAITING, F_HOLDING} fetch_state_t;

   fetch_state_t   state;
   cpu_pkg::addr_t pc;
   logic           stopped;      // HALT already handed to decode

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= F_REQUEST;
         pc      <= '0;
         stopped <= 1'b0;
      end else begin
         case (state)
            F_REQUEST: begin
               if (!(halt || stopped)) begin
                  state <= F_WAITING;
               end
            end
            F_WAITING: begin
               if (req_done) begin
                  state <= F_HOLDING;
               end
            end
            F_HOLDING: begin
               if (instr_take) begin
                  pc    <= pc + 1'b1;
                  state <= F_REQUEST;
                  // Nothing past HALT gets read
                  if (instr.opcode == cpu_pkg::OP_HALT) begin
                     stopped <= 1'b1;
                  end
               end
            end
            default: state <= F_REQUEST;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == F_WAITING && req_done) begin
         instr <= cpu_pkg::instr_t'(rdata);
      end
   end

   assign instr_valid = (state == F_HOLDING);
   assign req_valid   = (state == F_WAITING) || (state == F_REQUEST && !halt && !stopped);
   assign req         = '{rw: 1'b0, addr: pc, wdata: '0};   // Reads only

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

   localparam int NUM_REGS = 16;

   typedef logic [31:0] word_t;      // Data and instruction word
   typedef logic [15:0] addr_t;      // Word address
   typedef logic [3:0]  reg_idx_t;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_ADDI = 4'h4,
      OP_MUL  = 4'h5,
      OP_SW   = 4'h6,
      OP_HALT = 4'h7
   } opcode_t;

   // Field layout of a fetched word, opcode in the top nibble
   typedef struct packed {
      opcode_t     opcode;
      reg_idx_t    rd;
      reg_idx_t    rs1;
      reg_idx_t    rs2;
      logic [15:0] imm;
   } instr_t;

   typedef struct packed {
      logic     valid;
      opcode_t  op;
      reg_idx_t rd;
      word_t    a;
      word_t    b;              // Already muxed, immediate for ADDI
   } issue_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } wb_t;

   typedef struct packed {
      logic  rw;                // High for a write
      addr_t addr;
      word_t wdata;
   } mem_req_t;

endpackage
